/* common/fpsu_macros.svh */
`ifndef FPSU_MACROS_SVH
`define FPSU_MACROS_SVH

// ###################################################################
// Widths
// ###################################################################
`define FPSU_LANE_W   32  // One single-precision lane
`define FPSU_DATA_W   64  // Two lanes side by side
`define FPSU_RET_W    4   // Return code, one bit per fpsu_ret_e entry
`define FPSU_CSR_W    32

// ###################################################################
// Control register and timing
// ###################################################################
`define FPSU_CSR_DAZ  0   // Denormals-as-zero enable
`define FPSU_LATENCY  2   // Issue to return, in cycles

`define FPSU_QNAN     32'h7fc0_0000  // Canonical quiet NaN

`endif

/* common/fpsu_pkg.sv */
package fpsu_pkg;

  // ###################################################################
  // Operation codes
  // ###################################################################
  typedef enum logic [2:0] {
    OP_MOV   = 3'd0,  // A
    OP_ABS   = 3'd1,  // A with sign cleared
    OP_NEG   = 3'd2,  // A with sign inverted
    OP_SGNJ  = 3'd3,  // Magnitude of A, sign of B
    OP_MIN   = 3'd4,  // IEEE minNum
    OP_MAX   = 3'd5,  // IEEE maxNum
    OP_SWAP  = 3'd6,  // Exchange the halves
    OP_DUPLO = 3'd7   // Low half copied into both halves
  } fpsu_op_e;

  // ###################################################################
  // Operand sources
  // ###################################################################
  typedef enum logic [1:0] {
    SRC_REG = 2'd0,  // Register operand of the half
    SRC_FWD = 2'd1,  // Most recent result of the half
    SRC_ALT = 2'd2   // Alternate data input
  } fpsu_src_e;

  // ###################################################################
  // Return code bit positions
  // ###################################################################
  // Each half reports only what its own lane saw, the top ORs them
  typedef enum logic [1:0] {
    RET_NV     = 2'd0,  // Signaling NaN reached min or max
    RET_NAN    = 2'd1,  // A read operand was a NaN
    RET_ZERO   = 2'd2,  // Lane result is a signed zero
    RET_DENORM = 2'd3   // A subnormal operand was flushed
  } fpsu_ret_e;

endpackage

/* flist.f */
+incdir+common
common/fpsu_pkg.sv
fpsu/fpsu_lane_alu.sv
fpsu/fpsu_half.sv
fpsu/fpsu_both.sv
test/fpsu_tb.sv

/* fpsu/fpsu_both.sv */
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_both (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`FPSU_CSR_W-1:0]  fpcsr,
  input  logic                    en,
  input  fpsu_pkg::fpsu_op_e      op,
  input  fpsu_pkg::fpsu_src_e     src_a,
  input  fpsu_pkg::fpsu_src_e     src_b,
  input  logic [`FPSU_DATA_W-1:0] a,
  input  logic [`FPSU_DATA_W-1:0] b,
  input  logic [`FPSU_DATA_W-1:0] alt_data,
  output logic [`FPSU_DATA_W-1:0] result,
  output logic [`FPSU_RET_W-1:0]  ret,
  output logic                    ret_en
);

  logic [`FPSU_LANE_W-1:0] lo_cross_a;
  logic [`FPSU_LANE_W-1:0] hi_cross_a;
  logic [`FPSU_RET_W-1:0]  lo_ret;
  logic [`FPSU_RET_W-1:0]  hi_ret;
  logic                    lo_ret_en;
  logic                    hi_ret_en;

  // ###################################################################
  // Lane slices
  // ###################################################################
  fpsu_half #(
    .HIGH (0)
  ) u_half_lo (
    .clk     (clk),
    .rst_n   (rst_n),
    .fpcsr   (fpcsr),
    .en      (en),
    .op      (op),
    .src_a   (src_a),
    .src_b   (src_b),
    .a       (a[`FPSU_LANE_W-1:0]),
    .b       (b[`FPSU_LANE_W-1:0]),
    .alt     (alt_data[`FPSU_LANE_W-1:0]),
    .peer_a  (hi_cross_a),
    .cross_a (lo_cross_a),
    .result  (result[`FPSU_LANE_W-1:0]),
    .ret     (lo_ret),
    .ret_en  (lo_ret_en)
  );

  fpsu_half #(
    .HIGH (1)
  ) u_half_hi (
    .clk     (clk),
    .rst_n   (rst_n),
    .fpcsr   (fpcsr),
    .en      (en),
    .op      (op),
    .src_a   (src_a),
    .src_b   (src_b),
    .a       (a[`FPSU_DATA_W-1:`FPSU_LANE_W]),
    .b       (b[`FPSU_DATA_W-1:`FPSU_LANE_W]),
    .alt     (alt_data[`FPSU_DATA_W-1:`FPSU_LANE_W]),
    .peer_a  (lo_cross_a),
    .cross_a (hi_cross_a),
    .result  (result[`FPSU_DATA_W-1:`FPSU_LANE_W]),
    .ret     (hi_ret),
    .ret_en  (hi_ret_en)
  );

  // Both halves issue together, so the enables line up
  assign ret    = lo_ret | hi_ret;
  assign ret_en = lo_ret_en | hi_ret_en;

endmodule

/* fpsu/fpsu_half.sv */
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_half #(
  parameter int unsigned HIGH = 0  // 1 for the upper lane
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`FPSU_CSR_W-1:0]  fpcsr,
  input  logic                    en,
  input  fpsu_pkg::fpsu_op_e      op,
  input  fpsu_pkg::fpsu_src_e     src_a,
  input  fpsu_pkg::fpsu_src_e     src_b,
  input  logic [`FPSU_LANE_W-1:0] a,
  input  logic [`FPSU_LANE_W-1:0] b,
  input  logic [`FPSU_LANE_W-1:0] alt,
  input  logic [`FPSU_LANE_W-1:0] peer_a,
  output logic [`FPSU_LANE_W-1:0] cross_a,
  output logic [`FPSU_LANE_W-1:0] result,
  output logic [`FPSU_RET_W-1:0]  ret,
  output logic                    ret_en
);

  logic [`FPSU_LANE_W-1:0] sel_a;
  logic [`FPSU_LANE_W-1:0] sel_b;

  logic                    s1_vld;
  fpsu_pkg::fpsu_op_e      s1_op;
  logic [`FPSU_LANE_W-1:0] s1_a;
  logic [`FPSU_LANE_W-1:0] s1_b;
  logic [`FPSU_LANE_W-1:0] s1_peer;
  logic [`FPSU_CSR_W-1:0]  s1_csr;

  fpsu_pkg::fpsu_op_e      alu_op;
  logic [`FPSU_LANE_W-1:0] alu_res;
  logic [`FPSU_RET_W-1:0]  alu_flags;

  function automatic logic [`FPSU_LANE_W-1:0] pick(input fpsu_pkg::fpsu_src_e     src,
                                                    input logic [`FPSU_LANE_W-1:0] reg_v,
                                                    input logic [`FPSU_LANE_W-1:0] fwd_v,
                                                    input logic [`FPSU_LANE_W-1:0] alt_v);
    case (src)
      fpsu_pkg::SRC_FWD: return fwd_v;
      fpsu_pkg::SRC_ALT: return alt_v;
      default:           return reg_v;
    endcase
  endfunction

  // ###################################################################
  // Operand select
  // ###################################################################
  assign sel_a   = pick(src_a, a, result, alt);  // Forward is the result register
  assign sel_b   = pick(src_b, b, result, alt);
  assign cross_a = sel_a;  // Other half latches it as its peer

  // ###################################################################
  // Stage 1
  // ###################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      s1_op  <= fpsu_pkg::OP_MOV;
    end else begin
      s1_vld <= en;
      if (en) begin
        s1_op <= op;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_a    <= sel_a;
      s1_b    <= sel_b;
      s1_peer <= peer_a;  // Same edge as the other half's A
      s1_csr  <= fpcsr;   // DAZ as seen at issue
    end
  end

  // Low half keeps its own A on DUPLO, which is a plain move here
  always_comb begin
    if (HIGH == 0 && s1_op == fpsu_pkg::OP_DUPLO) begin
      alu_op = fpsu_pkg::OP_MOV;
    end else begin
      alu_op = s1_op;
    end
  end

  fpsu_lane_alu u_alu (
    .fpcsr (s1_csr),
    .op    (alu_op),
    .opa   (s1_a),
    .opb   (s1_b),
    .peer  (s1_peer),
    .res   (alu_res),
    .flags (alu_flags)
  );

  // ###################################################################
  // Stage 2
  // ###################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
      ret    <= '0;
      ret_en <= 1'b0;
    end else begin
      ret_en <= s1_vld;
      ret    <= s1_vld ? alu_flags : '0;
      if (s1_vld) begin
        result <= alu_res;  // Holds between returns for forwarding
      end
    end
  end

endmodule

/* fpsu/fpsu_lane_alu.sv */
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_lane_alu (
  input  logic [`FPSU_CSR_W-1:0]  fpcsr,
  input  fpsu_pkg::fpsu_op_e      op,
  input  logic [`FPSU_LANE_W-1:0] opa,
  input  logic [`FPSU_LANE_W-1:0] opb,
  input  logic [`FPSU_LANE_W-1:0] peer,
  output logic [`FPSU_LANE_W-1:0] res,
  output logic [`FPSU_RET_W-1:0]  flags
);

  logic                    daz;
  logic [`FPSU_LANE_W-1:0] fa;
  logic [`FPSU_LANE_W-1:0] fb;
  logic [`FPSU_LANE_W-1:0] fp;
  logic                    a_sub;
  logic                    b_sub;
  logic                    a_nan;
  logic                    b_nan;
  logic                    a_snan;
  logic                    b_snan;
  logic                    a_lt_b;
  logic                    is_mm;
  logic                    is_max;
  logic                    rd_a;
  logic                    rd_b;
  logic [`FPSU_LANE_W-1:0] mm_res;

  function automatic logic is_sub(input logic [`FPSU_LANE_W-1:0] x);
    return (x[30:23] == 8'h00) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_nan(input logic [`FPSU_LANE_W-1:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  // Subnormal becomes a zero of the same sign
  function automatic logic [`FPSU_LANE_W-1:0] flush(input logic                    on,
                                                     input logic [`FPSU_LANE_W-1:0] x);
    return (on && is_sub(x)) ? {x[31], 31'd0} : x;
  endfunction

  // ###################################################################
  // Operand classification
  // ###################################################################
  assign daz    = fpcsr[`FPSU_CSR_DAZ];
  assign a_sub  = is_sub(opa);
  assign b_sub  = is_sub(opb);
  assign fa     = flush(daz, opa);
  assign fb     = flush(daz, opb);
  assign fp     = flush(daz, peer);  // Owner lane flags this one
  assign a_nan  = is_nan(fa);
  assign b_nan  = is_nan(fb);
  assign a_snan = a_nan & ~fa[22];   // Quiet bit clear
  assign b_snan = b_nan & ~fb[22];

  assign is_mm  = (op == fpsu_pkg::OP_MIN) || (op == fpsu_pkg::OP_MAX);
  assign is_max = (op == fpsu_pkg::OP_MAX);

  // A feeds every op except DUPLO, where the lane only copies its peer
  assign rd_a = (op != fpsu_pkg::OP_DUPLO);
  assign rd_b = is_mm || (op == fpsu_pkg::OP_SGNJ);

  // ###################################################################
  // minNum / maxNum
  // ###################################################################
  always_comb begin
    if (fa[31] != fb[31]) begin
      a_lt_b = fa[31];  // Negative side is lower, -0 below +0
    end else if (fa[31]) begin
      a_lt_b = fa[30:0] > fb[30:0];
    end else begin
      a_lt_b = fa[30:0] < fb[30:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      mm_res = `FPSU_QNAN;
    end else if (a_nan) begin
      mm_res = fb;
    end else if (b_nan) begin
      mm_res = fa;
    end else if (a_lt_b ^ is_max) begin
      mm_res = fa;
    end else begin
      mm_res = fb;
    end
  end

  // ###################################################################
  // Result and flags
  // ###################################################################
  always_comb begin
    case (op)
      fpsu_pkg::OP_MOV:   res = fa;
      fpsu_pkg::OP_ABS:   res = {1'b0, fa[30:0]};
      fpsu_pkg::OP_NEG:   res = {~fa[31], fa[30:0]};
      fpsu_pkg::OP_SGNJ:  res = {fb[31], fa[30:0]};
      fpsu_pkg::OP_MIN:   res = mm_res;
      fpsu_pkg::OP_MAX:   res = mm_res;
      fpsu_pkg::OP_SWAP:  res = fp;
      fpsu_pkg::OP_DUPLO: res = fp;
      default:            res = fa;
    endcase
  end

  always_comb begin
    flags                       = '0;
    flags[fpsu_pkg::RET_NV]     = is_mm && (a_snan || b_snan);
    flags[fpsu_pkg::RET_NAN]    = (rd_a && a_nan) || (rd_b && b_nan);
    flags[fpsu_pkg::RET_ZERO]   = (res[30:0] == 31'd0);
    flags[fpsu_pkg::RET_DENORM] = daz && ((rd_a && a_sub) || (rd_b && b_sub));
  end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fpsu_tb -f flist.f -o fpsu_sim
out=$(./obj_dir/fpsu_sim || true)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

/* test/fpsu_tb.sv */
`timescale 1ns/1ps
`include "fpsu_macros.svh"

module fpsu_tb;

  localparam int N_SIGN   = 60;
  localparam int N_MINMAX = 80;
  localparam int N_SHUF   = 60;
  localparam int N_CHAIN  = 40;
  localparam int N_DAZ    = 80;
  localparam int N_MIX    = 100;
  localparam int N_ISSUES = N_SIGN + N_MINMAX + N_SHUF + N_CHAIN + 2 * N_DAZ + N_MIX + 10;
  localparam int LIMIT_NS = (2 * N_ISSUES + 100) * 100;  // Random gaps at most double the cycles

  logic                    clk;
  logic                    rst_n;
  logic [`FPSU_CSR_W-1:0]  fpcsr;
  logic                    en;
  fpsu_pkg::fpsu_op_e      op;
  fpsu_pkg::fpsu_src_e     src_a;
  fpsu_pkg::fpsu_src_e     src_b;
  logic [`FPSU_DATA_W-1:0] a;
  logic [`FPSU_DATA_W-1:0] b;
  logic [`FPSU_DATA_W-1:0] alt_data;
  logic [`FPSU_DATA_W-1:0] result;
  logic [`FPSU_RET_W-1:0]  ret;
  logic                    ret_en;

  logic [15:0]  lfsr;
  int           cyc = 0;
  logic [63:0]  fwd_q;          // Model of the result register
  logic         d1_vld;
  logic [63:0]  d1_res;
  logic [63:0]  sel_a;
  logic [63:0]  sel_b;
  logic [67:0]  model_v;
  logic [99:0]  expq[$];        // {issue cycle, ret, result}
  logic [99:0]  ent;
  int           due;

  fpsu_both i_fpsu_both (
    .clk      (clk),
    .rst_n    (rst_n),
    .fpcsr    (fpcsr),
    .en       (en),
    .op       (op),
    .src_a    (src_a),
    .src_b    (src_b),
    .a        (a),
    .b        (b),
    .alt_data (alt_data),
    .result   (result),
    .ret      (ret),
    .ret_en   (ret_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(LIMIT_NS);
    stop_with_failure("Timeout: the run did not finish in the expected number of cycles");
  end

  // ###################################################################
  // Error reporting
  // ###################################################################
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
    if (got !== want) begin
      stop_with_failure($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                  $time, what, got, want));
    end
  endtask

  // ###################################################################
  // Random stimulus
  // ###################################################################
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Pool leans on NaNs, zeros and subnormals
  task automatic rand_lane(output logic [31:0] v);
    logic [31:0] kind;
    logic [31:0] sgn;
    logic [31:0] man;
    logic [31:0] ex;
    take_bits(3, kind);
    take_bits(1, sgn);
    take_bits(23, man);
    take_bits(8, ex);
    case (kind[2:0])
      3'd0:    v = {sgn[0], 8'hff, 1'b1, man[21:0]};        // Quiet NaN
      3'd1:    v = {sgn[0], 8'hff, 1'b0, man[21:1], 1'b1};  // Signaling NaN
      3'd2:    v = {sgn[0], 31'd0};
      3'd3:    v = {sgn[0], 8'h00, man[22:1], 1'b1};        // Subnormal
      3'd4:    v = {sgn[0], 8'hff, 23'd0};                  // Infinity
      default: v = {sgn[0], ex[7:0], man[22:0]};
    endcase
  endtask

  task automatic rand_word(output logic [63:0] v);
    logic [31:0] lo;
    logic [31:0] hi;
    rand_lane(lo);
    rand_lane(hi);
    v = {hi, lo};
  endtask

  function automatic fpsu_pkg::fpsu_src_e src_of(input logic [1:0] r);
    return (r == 2'd3) ? fpsu_pkg::SRC_FWD : fpsu_pkg::fpsu_src_e'(r);
  endfunction

  // ###################################################################
  // Reference model
  // ###################################################################
  function automatic logic f32_is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic f32_is_snan(input logic [31:0] x);
    return f32_is_nan(x) && !x[22];
  endfunction

  function automatic logic f32_is_sub(input logic [31:0] x);
    return (x[30:23] == 8'h00) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic [31:0] daz_flush(input logic [31:0] x, input logic daz);
    return (daz && f32_is_sub(x)) ? {x[31], 31'd0} : x;
  endfunction

  function automatic logic [63:0] select_operand(input fpsu_pkg::fpsu_src_e src,
                                                 input logic [63:0] reg_v, fwd_v, alt_v);
    if (src == fpsu_pkg::SRC_FWD) begin
      return fwd_v;
    end else if (src == fpsu_pkg::SRC_ALT) begin
      return alt_v;
    end
    return reg_v;
  endfunction

  // Returns {flags, result} of one lane where vp is the A operand of the other lane
  function automatic logic [35:0] lane_model(input fpsu_pkg::fpsu_op_e o, input logic high,
                                             input logic [31:0] va, vb, vp, input logic daz);
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] fp;
    logic [31:0] res;
    logic [3:0]  flags;
    logic        a_rd;
    logic        b_rd;
    logic        a_less;
    fa     = daz_flush(va, daz);
    fb     = daz_flush(vb, daz);
    fp     = daz_flush(vp, daz);
    a_rd   = 1'b1;
    b_rd   = 1'b0;
    flags  = '0;
    if (fa[31] != fb[31]) begin
      a_less = fa[31];
    end else begin
      a_less = fa[31] ? (fa[30:0] > fb[30:0]) : (fa[30:0] < fb[30:0]);
    end
    case (o)
      fpsu_pkg::OP_MOV:  res = fa;
      fpsu_pkg::OP_ABS:  res = {1'b0, fa[30:0]};
      fpsu_pkg::OP_NEG:  res = {~fa[31], fa[30:0]};
      fpsu_pkg::OP_SGNJ: begin
        res  = {fb[31], fa[30:0]};
        b_rd = 1'b1;
      end
      fpsu_pkg::OP_MIN, fpsu_pkg::OP_MAX: begin
        b_rd = 1'b1;
        flags[fpsu_pkg::RET_NV] = f32_is_snan(fa) || f32_is_snan(fb);
        if (f32_is_nan(fa) && f32_is_nan(fb)) begin
          res = `FPSU_QNAN;
        end else if (f32_is_nan(fa)) begin
          res = fb;
        end else if (f32_is_nan(fb)) begin
          res = fa;
        end else if (o == fpsu_pkg::OP_MIN) begin
          res = a_less ? fa : fb;
        end else begin
          res = a_less ? fb : fa;
        end
      end
      fpsu_pkg::OP_SWAP: res = fp;
      default: begin
        res  = high ? fp : fa;  // Own A of the high lane is unused
        a_rd = !high;
      end
    endcase
    flags[fpsu_pkg::RET_NAN]    = (a_rd && f32_is_nan(fa)) || (b_rd && f32_is_nan(fb));
    flags[fpsu_pkg::RET_ZERO]   = (res[30:0] == 31'd0);
    flags[fpsu_pkg::RET_DENORM] = daz && ((a_rd && f32_is_sub(va)) || (b_rd && f32_is_sub(vb)));
    return {flags, res};
  endfunction

  function automatic logic [67:0] fpsu_model(input fpsu_pkg::fpsu_op_e o,
                                             input logic [63:0] va, vb,
                                             input logic [`FPSU_CSR_W-1:0] csr);
    logic [35:0] lo;
    logic [35:0] hi;
    logic        daz;
    daz = csr[`FPSU_CSR_DAZ];
    lo  = lane_model(o, 1'b0, va[31:0], vb[31:0], va[63:32], daz);
    hi  = lane_model(o, 1'b1, va[63:32], vb[63:32], va[31:0], daz);
    return {lo[35:32] | hi[35:32], hi[31:0], lo[31:0]};
  endfunction

  // ###################################################################
  // Model and compare
  // ###################################################################
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst_n) begin
      fwd_q  = '0;
      d1_vld = 1'b0;
    end else begin
      model_v = '0;
      if (en) begin
        sel_a   = select_operand(src_a, a, fwd_q, alt_data);  // Register value before this edge
        sel_b   = select_operand(src_b, b, fwd_q, alt_data);
        model_v = fpsu_model(op, sel_a, sel_b, fpcsr);
        expq.push_back({cyc - 1, model_v});  // en was driven on the edge before
      end
      if (d1_vld) begin
        fwd_q = d1_res;  // Written back one edge after the operands were taken
      end
      d1_vld = en;
      d1_res = model_v[63:0];
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      if (ret_en) begin
        if (expq.size() == 0) begin
          stop_with_failure("ret_en went high with no operation in flight");
        end else begin
          ent = expq.pop_front();
          check(64'(cyc), 64'(ent[99:68]) + `FPSU_LATENCY, "return cycle");
          check(result, ent[63:0], "result");
          check(64'(ret), 64'(ent[67:64]), "ret");
        end
      end else if (expq.size() != 0) begin
        due = int'(expq[0][99:68]) + `FPSU_LATENCY;
        if (cyc >= due) begin
          stop_with_failure("An issued operation did not return on time");
        end
      end
    end
  end

  // ###################################################################
  // Stimulus
  // ###################################################################
  task automatic issue(input fpsu_pkg::fpsu_op_e o, input fpsu_pkg::fpsu_src_e sa, sb,
                       input logic [63:0] va, vb, valt);
    @(posedge clk);
    en       <= 1'b1;
    op       <= o;
    src_a    <= sa;
    src_b    <= sb;
    a        <= va;
    b        <= vb;
    alt_data <= valt;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      en <= 1'b0;
    end
  endtask

  task automatic set_daz(input logic on);
    @(posedge clk);
    en                   <= 1'b0;
    fpcsr[`FPSU_CSR_DAZ] <= on;
  endtask

  // Mode 0 uses registers, 1 any source with gaps, 2 forwards A back to back
  task automatic random_issues(input int n, input int op_lo, input int op_span, input int mode);
    logic [31:0]         r;
    logic [63:0]         va;
    logic [63:0]         vb;
    logic [63:0]         valt;
    fpsu_pkg::fpsu_src_e sa;
    fpsu_pkg::fpsu_src_e sb;
    int                  idx;
    int                  k;
    for (k = 0; k < n; k++) begin
      rand_word(va);
      rand_word(vb);
      rand_word(valt);
      take_bits(3, r);
      idx = op_lo + int'(r % op_span);
      take_bits(2, r);
      sa = (mode == 0) ? fpsu_pkg::SRC_REG : (mode == 2) ? fpsu_pkg::SRC_FWD : src_of(r[1:0]);
      take_bits(2, r);
      sb = (mode == 0) ? fpsu_pkg::SRC_REG : src_of(r[1:0]);
      take_bits(1, r);
      if (mode == 1 && r[0]) begin
        idle(1);
      end
      issue(fpsu_pkg::fpsu_op_e'(idx[2:0]), sa, sb, va, vb, valt);
    end
  endtask

  initial begin
    lfsr     = 16'd31023;
    rst_n    = 1'b0;
    fpcsr    = '0;
    en       = 1'b0;
    op       = fpsu_pkg::OP_MOV;
    src_a    = fpsu_pkg::SRC_REG;
    src_b    = fpsu_pkg::SRC_REG;
    a        = '0;
    b        = '0;
    alt_data = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check(result, '0, "result after reset");
    check(64'(ret), 64'd0, "ret after reset");
    check(64'(ret_en), 64'd0, "ret_en after reset");

    issue(fpsu_pkg::OP_MOV, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'hc000_0000, 32'h3f80_0000}, '0, '0);
    idle(4);
    random_issues(N_SIGN, 0, 4, 0);

    // Signed zeros, signaling NaN and a double NaN
    issue(fpsu_pkg::OP_MIN, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'h8000_0000, 32'h7f80_0001}, {32'h0000_0000, 32'h3f80_0000}, '0);
    issue(fpsu_pkg::OP_MAX, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'h8000_0000, 32'h7f80_0001}, {32'h0000_0000, 32'h3f80_0000}, '0);
    issue(fpsu_pkg::OP_MAX, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'h7fc0_0000, 32'hff80_0000}, {32'h7f80_0002, 32'h8000_0000}, '0);
    random_issues(N_MINMAX, 4, 2, 0);
    idle(3);

    issue(fpsu_pkg::OP_SWAP, fpsu_pkg::SRC_ALT, fpsu_pkg::SRC_REG,
          '0, '0, {32'h1234_5678, 32'hbf80_0000});
    issue(fpsu_pkg::OP_DUPLO, fpsu_pkg::SRC_FWD, fpsu_pkg::SRC_REG, '0, '0, '0);
    random_issues(N_SHUF, 6, 2, 1);
    random_issues(N_CHAIN, 0, 8, 2);

    set_daz(1'b1);
    issue(fpsu_pkg::OP_MOV, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'h8000_0001, 32'h0040_0000}, '0, '0);
    random_issues(N_DAZ, 0, 8, 1);
    set_daz(1'b0);
    issue(fpsu_pkg::OP_MOV, fpsu_pkg::SRC_REG, fpsu_pkg::SRC_REG,
          {32'h8000_0001, 32'h0040_0000}, '0, '0);
    random_issues(N_DAZ, 0, 8, 1);
    random_issues(N_MIX, 0, 8, 1);
    idle(`FPSU_LATENCY + 2);

    if (expq.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_with_failure("Some issued operations never returned");
    end
  end

endmodule
